// ==== cpu_pkg.sv ====
package cpu_pkg;

   // primary opcode, instr[31:26]
   typedef enum logic [5:0] {
      SPECIAL = 6'h00,
      J       = 6'h02,
      JAL     = 6'h03,
      BEQ     = 6'h04,
      BNE     = 6'h05,
      ADDI    = 6'h08,
      SLTI    = 6'h0a,
      ANDI    = 6'h0c,
      ORI     = 6'h0d,
      XORI    = 6'h0e,
      LUI     = 6'h0f
   } opcode_e;

   // function field of SPECIAL, instr[5:0]
   typedef enum logic [5:0] {
      SLL = 6'h00,
      SRL = 6'h02,
      JR  = 6'h08,
      ADD = 6'h20,
      SUB = 6'h22,
      AND = 6'h24,
      OR  = 6'h25,
      XOR = 6'h26,
      SLT = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,   // signed compare
      ALU_SLL,
      ALU_SRL,
      ALU_LUI,
      ALU_LINK,  // return address for jal
      ALU_NONE
   } alu_op_e;

   typedef enum logic {SRC_RT, SRC_IMM} src_b_e;

   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_JUMP,  // j and jal
      BR_REG    // jr
   } br_kind_e;

   // decode to execute
   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] rs_val;
      logic [31:0] rt_val;
      logic [4:0]  rs_num;
      logic [4:0]  rt_num;
      logic [31:0] imm;         // already extended
      logic [4:0]  shamt;
      alu_op_e     alu_op;
      src_b_e      src_b;
      logic [4:0]  dest_num;
      logic        wr_en;       // low for r0
      br_kind_e    br_kind;
      logic [25:0] jump_index;
   } id_ex_t;

   // execute to writeback, also the register file write port
   typedef struct packed {
      logic        valid;
      logic        wr_en;
      logic [4:0]  dest_num;
      logic [31:0] data;
   } ex_wb_t;

endpackage

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic [4:0]  i_rs_num,
   input  logic [4:0]  i_rt_num,
   input  ex_wb_t      i_wb,
   output logic [31:0] o_rs_val,
   output logic [31:0] o_rt_val
);

   logic [31:0] regs [1:31];  // r0 has no storage
   logic        wr;

   assign wr = i_wb.valid && i_wb.wr_en && (i_wb.dest_num != 5'd0);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr) begin
         regs[i_wb.dest_num] <= i_wb.data;
      end
   end

   // one read port, new data wins over the stored value
   function automatic logic [31:0] read_reg(input logic [4:0] num);
      logic [31:0] val;
      if (num == 5'd0) begin
         val = '0;
      end else if (wr && (i_wb.dest_num == num)) begin
         val = i_wb.data;  // write-through
      end else begin
         val = regs[num];
      end
      return val;
   endfunction

   always_comb begin
      o_rs_val = read_reg(i_rs_num);
      o_rt_val = read_reg(i_rt_num);
   end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_instr_stb,
   input  logic [31:0] i_instr,
   input  logic [31:0] i_pc,
   input  ex_wb_t      i_wb,
   output id_ex_t      o_id_ex
);

   typedef enum logic {EXT_SIGN, EXT_ZERO} ext_e;

   opcode_e     opcode;
   funct_e      funct;
   logic [4:0]  rs_num;
   logic [4:0]  rt_num;
   logic [4:0]  rd_num;
   logic [4:0]  shamt;
   logic [31:0] rs_val;
   logic [31:0] rt_val;
   logic [31:0] imm;

   // control
   alu_op_e     alu_op;
   src_b_e      src_b;
   ext_e        ext;
   logic [4:0]  dest_num;
   logic        wr_en;
   br_kind_e    br_kind;

   assign opcode = opcode_e'(i_instr[31:26]);
   assign funct  = funct_e'(i_instr[5:0]);
   assign rs_num = i_instr[25:21];
   assign rt_num = i_instr[20:16];
   assign rd_num = i_instr[15:11];
   assign shamt  = i_instr[10:6];

   assign imm = (ext == EXT_SIGN) ? {{16{i_instr[15]}}, i_instr[15:0]}
                                  : {16'h0000, i_instr[15:0]};

   always_comb begin
      // defaults give a no-op
      alu_op   = ALU_NONE;
      src_b    = SRC_IMM;
      ext      = EXT_SIGN;
      dest_num = rt_num;
      wr_en    = 1'b0;
      br_kind  = BR_NONE;
      case (opcode)
         SPECIAL: begin
            src_b    = SRC_RT;
            dest_num = rd_num;
            wr_en    = 1'b1;
            case (funct)
               SLL: alu_op = ALU_SLL;
               SRL: alu_op = ALU_SRL;
               ADD: alu_op = ALU_ADD;
               SUB: alu_op = ALU_SUB;
               AND: alu_op = ALU_AND;
               OR:  alu_op = ALU_OR;
               XOR: alu_op = ALU_XOR;
               SLT: alu_op = ALU_SLT;
               JR: begin
                  wr_en   = 1'b0;
                  br_kind = BR_REG;
               end
               default: wr_en = 1'b0;  // mult, div, etc. do nothing
            endcase
         end
         J:   br_kind = BR_JUMP;
         JAL: begin
            br_kind  = BR_JUMP;
            alu_op   = ALU_LINK;
            dest_num = 5'd31;
            wr_en    = 1'b1;
         end
         BEQ: br_kind = BR_EQ;
         BNE: br_kind = BR_NE;
         ADDI: begin
            alu_op = ALU_ADD;
            wr_en  = 1'b1;
         end
         SLTI: begin
            alu_op = ALU_SLT;
            wr_en  = 1'b1;
         end
         ANDI: begin
            alu_op = ALU_AND;
            ext    = EXT_ZERO;
            wr_en  = 1'b1;
         end
         ORI: begin
            alu_op = ALU_OR;
            ext    = EXT_ZERO;
            wr_en  = 1'b1;
         end
         XORI: begin
            alu_op = ALU_XOR;
            ext    = EXT_ZERO;
            wr_en  = 1'b1;
         end
         LUI: begin
            alu_op = ALU_LUI;  // alu moves imm to the upper half
            ext    = EXT_ZERO;
            wr_en  = 1'b1;
         end
         default: ;  // loads, stores, halt
      endcase
   end

   reg_file u_reg_file (
      .i_clk    (i_clk),
      .i_rst    (i_rst),
      .i_rs_num (rs_num),
      .i_rt_num (rt_num),
      .i_wb     (i_wb),
      .o_rs_val (rs_val),
      .o_rt_val (rt_val)
   );

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_id_ex <= '0;
      end else begin
         o_id_ex.valid      <= i_instr_stb;
         o_id_ex.pc         <= i_pc;
         o_id_ex.rs_val     <= rs_val;
         o_id_ex.rt_val     <= rt_val;
         o_id_ex.rs_num     <= rs_num;
         o_id_ex.rt_num     <= rt_num;
         o_id_ex.imm        <= imm;
         o_id_ex.shamt      <= shamt;
         o_id_ex.alu_op     <= alu_op;
         o_id_ex.src_b      <= src_b;
         o_id_ex.dest_num   <= dest_num;
         o_id_ex.wr_en      <= wr_en && (dest_num != 5'd0);  // r0 never written
         o_id_ex.br_kind    <= br_kind;
         o_id_ex.jump_index <= i_instr[25:0];
      end
   end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
   input  alu_op_e     i_op,
   input  logic [31:0] i_a,
   input  logic [31:0] i_b,
   input  logic [4:0]  i_shamt,
   input  logic [31:0] i_pc,
   output logic [31:0] o_result
);

   logic signed [31:0] a_s;
   logic signed [31:0] b_s;

   assign a_s = i_a;
   assign b_s = i_b;

   always_comb begin
      case (i_op)
         ALU_ADD: begin
            o_result = i_a + i_b;  // wraps, no trap
         end
         ALU_SUB: begin
            o_result = i_a - i_b;
         end
         ALU_AND: begin
            o_result = i_a & i_b;
         end
         ALU_OR: begin
            o_result = i_a | i_b;
         end
         ALU_XOR: begin
            o_result = i_a ^ i_b;
         end
         ALU_SLT: begin
            o_result = {31'd0, (a_s < b_s)};
         end
         // shifts act on rt by shamt
         ALU_SLL: begin
            o_result = i_b << i_shamt;
         end
         ALU_SRL: begin
            o_result = i_b >> i_shamt;
         end
         ALU_LUI: begin
            o_result = {i_b[15:0], 16'h0000};
         end
         ALU_LINK: begin
            o_result = i_pc + 32'd8;  // skips the delay slot
         end
         default: begin
            o_result = '0;
         end
      endcase
   end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  id_ex_t      i_id_ex,
   output ex_wb_t      o_wb,
   output logic        o_redirect_stb,
   output logic [31:0] o_redirect_pc
);

   logic [31:0] rs_fwd;
   logic [31:0] rt_fwd;
   logic [31:0] alu_b;
   logic [31:0] alu_result;
   logic [31:0] pc_plus4;
   logic [31:0] br_target;
   logic [31:0] jump_target;
   logic [31:0] target;
   logic        taken;

   // wb carries the instruction one ahead, older ones come via reg file
   assign rs_fwd = (o_wb.valid && o_wb.wr_en && (o_wb.dest_num == i_id_ex.rs_num))
                   ? o_wb.data : i_id_ex.rs_val;
   assign rt_fwd = (o_wb.valid && o_wb.wr_en && (o_wb.dest_num == i_id_ex.rt_num))
                   ? o_wb.data : i_id_ex.rt_val;

   assign alu_b = (i_id_ex.src_b == SRC_IMM) ? i_id_ex.imm : rt_fwd;

   alu u_alu (
      .i_op     (i_id_ex.alu_op),
      .i_a      (rs_fwd),
      .i_b      (alu_b),
      .i_shamt  (i_id_ex.shamt),
      .i_pc     (i_id_ex.pc),
      .o_result (alu_result)
   );

   assign pc_plus4    = i_id_ex.pc + 32'd4;
   assign br_target   = pc_plus4 + {i_id_ex.imm[29:0], 2'b00};
   assign jump_target = {pc_plus4[31:28], i_id_ex.jump_index, 2'b00};

   always_comb begin
      taken  = 1'b0;
      target = br_target;
      case (i_id_ex.br_kind)
         BR_EQ: begin
            taken = (rs_fwd == rt_fwd);
         end
         BR_NE: begin
            taken = (rs_fwd != rt_fwd);
         end
         BR_JUMP: begin
            taken  = 1'b1;
            target = jump_target;
         end
         BR_REG: begin
            taken  = 1'b1;
            target = rs_fwd;  // jr
         end
         default: begin
            taken = 1'b0;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_wb           <= '0;
         o_redirect_stb <= 1'b0;
         o_redirect_pc  <= '0;
      end else begin
         o_wb.valid     <= i_id_ex.valid;
         o_wb.wr_en     <= i_id_ex.valid && i_id_ex.wr_en;
         o_wb.dest_num  <= i_id_ex.dest_num;
         o_wb.data      <= alu_result;
         o_redirect_stb <= i_id_ex.valid && taken;  // same cycle as wb
         o_redirect_pc  <= target;
      end
   end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
   input  logic        i_clk,
   input  logic        i_rst,
   input  logic        i_instr_stb,
   input  logic [31:0] i_instr,
   input  logic [31:0] i_pc,
   output logic        o_wb_stb,
   output logic [4:0]  o_wb_reg,
   output logic [31:0] o_wb_data,
   output logic        o_redirect_stb,
   output logic [31:0] o_redirect_pc
);

   id_ex_t id_ex;
   ex_wb_t wb;  // result bus, also feeds the reg file and forwarding

   decode_stage u_decode (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_instr_stb (i_instr_stb),
      .i_instr     (i_instr),
      .i_pc        (i_pc),
      .i_wb        (wb),
      .o_id_ex     (id_ex)
   );

   execute_stage u_execute (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_id_ex        (id_ex),
      .o_wb           (wb),
      .o_redirect_stb (o_redirect_stb),
      .o_redirect_pc  (o_redirect_pc)
   );

   // strobe only for real register writes
   assign o_wb_stb  = wb.valid && wb.wr_en;
   assign o_wb_reg  = wb.dest_num;
   assign o_wb_data = wb.data;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #10 o_clk = ~o_clk;  // 20 ns period
   end

   // three rising edges in reset, released on a falling edge
   initial begin
      o_rst = 1'b1;
      repeat (3) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

// ==== cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker import cpu_pkg::*; (
   input logic   i_clk,
   input logic   i_rst,
   input id_ex_t i_id_ex,
   input ex_wb_t i_wb,
   input logic   i_redirect_stb
);

   int   fail_count = 0;  // read by the testbench at the end
   logic wb_stb;

   assign wb_stb = i_wb.valid && i_wb.wr_en;

   // r0 is never written
   a_no_r0_write: assert property (@(posedge i_clk) disable iff (i_rst)
      wb_stb |-> (i_wb.dest_num != 5'd0))
      else begin
         fail_count++;
         $error("writeback strobe with destination r0");
      end

   a_quiet_after_reset: assert property (@(posedge i_clk)
      (i_rst || $past(i_rst)) |=> (!wb_stb && !i_redirect_stb))  // also the cycle after release
      else begin
         fail_count++;
         $error("output strobe during or right after reset");
      end

   // only a valid jump or branch may redirect
   a_redirect_from_valid: assert property (@(posedge i_clk) disable iff (i_rst)
      i_redirect_stb |-> $past(i_id_ex.valid && (i_id_ex.br_kind != BR_NONE)))
      else begin
         fail_count++;
         $error("redirect without a valid jump or branch in execute");
      end

endmodule

bind execute_stage cpu_checker u_checker (
   .i_clk          (i_clk),
   .i_rst          (i_rst),
   .i_id_ex        (i_id_ex),
   .i_wb           (o_wb),
   .i_redirect_stb (o_redirect_stb)
);

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

   localparam int          N_INSTR = 2000;
   localparam logic [31:0] PC_BASE = 32'h0040_0000;

   // opcode pool, special weighted up, lw and 0x3f are unknown
   localparam logic [5:0] OPCODES [16] = '{6'h00, 6'h00, 6'h00, 6'h00, 6'h08, 6'h0a, 6'h0c,
                                           6'h0d, 6'h0e, 6'h0f, 6'h04, 6'h05, 6'h02, 6'h03,
                                           6'h23, 6'h3f};
   // function pool, mult and div are unknown
   localparam logic [5:0] FUNCTS [16] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h2a, 6'h00,
                                          6'h02, 6'h08, 6'h18, 6'h1a, 6'h20, 6'h22, 6'h2a,
                                          6'h00, 6'h02};

   typedef struct packed {
      logic [31:0] due;  // falling edge index where the result shows
      logic        wb_stb;
      logic [4:0]  wb_reg;
      logic [31:0] wb_data;
      logic        redir_stb;
      logic [31:0] redir_pc;
   } expect_t;

   logic        clk;
   logic        rst;
   logic        instr_stb;
   logic [31:0] instr;
   logic [31:0] pc;
   logic        wb_stb;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;
   logic        redirect_stb;
   logic [31:0] redirect_pc;

   logic [15:0] lfsr = 16'd32966;
   logic [31:0] mregs [32];  // reference register file
   expect_t     exp_q [$];
   int          n_checks = 0;
   int          n_errors = 0;
   int          n_sent = 0;
   int unsigned cyc = 0;

   tb_clock_gen u_clock_gen (.o_clk(clk), .o_rst(rst));

   cpu_core u_dut (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_instr_stb    (instr_stb),
      .i_instr        (instr),
      .i_pc           (pc),
      .o_wb_stb       (wb_stb),
      .o_wb_reg       (wb_reg),
      .o_wb_data      (wb_data),
      .o_redirect_stb (redirect_stb),
      .o_redirect_pc  (redirect_pc)
   );

   // fibonacci, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);  // one step per bit
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function logic [31:0] make_instr();
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  sh;
      logic [5:0]  fn;
      logic [31:0] w;
      op = OPCODES[4'(rand_bits(4))];
      rs = 5'(rand_bits(3));  // r0..r7 keeps dependencies close
      rt = 5'(rand_bits(3));
      rd = 5'(rand_bits(3));
      sh = 5'(rand_bits(5));
      fn = FUNCTS[4'(rand_bits(4))];
      if (op == 6'h00) begin
         w = {op, rs, rt, rd, sh, fn};
      end else if (op == 6'h02 || op == 6'h03) begin
         w = {op, 26'(rand_bits(26))};
      end else begin
         w = {op, rs, rt, 16'(rand_bits(16))};
      end
      return w;
   endfunction

   // executes at strobe time and updates the reference registers
   function expect_t model_exec(input logic [31:0] w, input logic [31:0] at_pc);
      expect_t     e;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sext;
      logic [31:0] zext;
      logic [31:0] pc4;
      logic [4:0]  dest;
      e = '0;
      a = mregs[w[25:21]];
      b = mregs[w[20:16]];
      sext = {{16{w[15]}}, w[15:0]};
      zext = {16'h0000, w[15:0]};
      pc4 = at_pc + 32'd4;
      dest = w[20:16];
      e.wb_stb = 1'b1;
      case (w[31:26])
         6'h00: begin
            dest = w[15:11];
            case (w[5:0])
               6'h20: e.wb_data = a + b;
               6'h22: e.wb_data = a - b;
               6'h24: e.wb_data = a & b;
               6'h25: e.wb_data = a | b;
               6'h26: e.wb_data = a ^ b;
               6'h2a: e.wb_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
               6'h00: e.wb_data = b << w[10:6];
               6'h02: e.wb_data = b >> w[10:6];
               6'h08: begin
                  e.wb_stb = 1'b0;
                  e.redir_stb = 1'b1;  // jr
                  e.redir_pc = a;
               end
               default: e.wb_stb = 1'b0;
            endcase
         end
         6'h02, 6'h03: begin
            e.wb_stb = (w[31:26] == 6'h03);  // jal links
            dest = 5'd31;
            e.wb_data = at_pc + 32'd8;
            e.redir_stb = 1'b1;
            e.redir_pc = {pc4[31:28], w[25:0], 2'b00};
         end
         6'h04, 6'h05: begin
            e.wb_stb = 1'b0;
            e.redir_stb = (w[26] == 1'b0) ? (a == b) : (a != b);
            e.redir_pc = pc4 + (sext << 2);
         end
         6'h08: e.wb_data = a + sext;
         6'h0a: e.wb_data = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
         6'h0c: e.wb_data = a & zext;
         6'h0d: e.wb_data = a | zext;
         6'h0e: e.wb_data = a ^ zext;
         6'h0f: e.wb_data = {w[15:0], 16'h0000};
         default: e.wb_stb = 1'b0;
      endcase
      if (dest == 5'd0) begin
         e.wb_stb = 1'b0;
      end
      e.wb_reg = dest;
      if (e.wb_stb) begin
         mregs[dest] = e.wb_data;
      end
      return e;
   endfunction

   // idle cycles expect both strobes low
   task check_outputs();
      expect_t e;
      e = '0;
      if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
         e = exp_q.pop_front();
      end
      n_checks++;
      if (wb_stb !== e.wb_stb) begin
         $display("ERROR %0t: o_wb_stb is %b, expected %b", $time, wb_stb, e.wb_stb);
         n_errors++;
      end else if (e.wb_stb && (wb_reg !== e.wb_reg || wb_data !== e.wb_data)) begin
         $display("ERROR %0t: writeback r%0d = %h, expected r%0d = %h", $time,
                  wb_reg, wb_data, e.wb_reg, e.wb_data);
         n_errors++;
      end
      if (redirect_stb !== e.redir_stb) begin
         $display("ERROR %0t: o_redirect_stb is %b, expected %b", $time,
                  redirect_stb, e.redir_stb);
         n_errors++;
      end else if (e.redir_stb && redirect_pc !== e.redir_pc) begin
         $display("ERROR %0t: redirect to %h, expected %h", $time, redirect_pc, e.redir_pc);
         n_errors++;
      end
   endtask

   initial begin
      expect_t e;
      instr_stb = 1'b0;
      instr = '0;
      pc = PC_BASE;
      for (int i = 0; i < 32; i++) begin
         mregs[i] = '0;
      end
      @(negedge rst);  // end of the reset pulse
      while (n_sent < N_INSTR || exp_q.size() > 0) begin
         @(negedge clk);
         check_outputs();
         if (n_sent < N_INSTR && rand_bits(1) == 32'd1) begin
            instr_stb = 1'b1;
            instr = make_instr();
            pc = PC_BASE + 32'(n_sent) * 32'd4;
            e = model_exec(instr, pc);
            e.due = cyc + 2;
            exp_q.push_back(e);
            n_sent++;
         end else begin
            instr_stb = 1'b0;
            instr = rand_bits(32);  // junk without strobe must be ignored
         end
         cyc++;
      end
      repeat (3) begin
         @(negedge clk);
         check_outputs();
         cyc++;
      end
      $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
               u_dut.u_execute.u_checker.fail_count);
      if (n_errors == 0 && u_dut.u_execute.u_checker.fail_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // about two cycles per instruction, plus slack
   initial begin
      #(N_INSTR * 40 + 20000);
      $display("timeout: the test did not finish in the expected time");
      $display("Regression failed");
      $finish;
   end

endmodule

// ==== flist.f ====
cpu_pkg.sv
reg_file.sv
decode_stage.sv
alu.sv
execute_stage.sv
cpu_core.sv
tb_clock_gen.sv
cpu_checker.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu regression with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f flist.f -o sim_cpu
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_cpu +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
   exit 0
fi
exit 1
